// File: logic/memStage_defs.svh
`ifndef MEMSTAGE_DEFS_SVH
`define MEMSTAGE_DEFS_SVH

// --------------------------------------------------
// Datapath sizes
// --------------------------------------------------
`define DATA_WIDTH  32      // Data word width
`define ADDR_WIDTH  12      // Byte address width

// --------------------------------------------------
// Data memory
// --------------------------------------------------
`define MEM_WORDS   1024    // RAM depth in words
`define MEM_LATENCY 2       // Request to ack inclusive and never below 1

// Event counters
`define COUNT_WIDTH 16

`endif

// File: logic/memStagePkg.sv
`include "memStage_defs.svh"

package memStagePkg;

    // Access size of a load or store
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } DataAccess;

    // Source of the register write-back value
    typedef enum logic {
        SEL_RESULT = 1'b0,              // ALU result
        SEL_MEMORY = 1'b1               // Extended load data
    } WrDataSel;

    // RAM sequencer
    typedef enum logic {
        IDLE = 1'b0,
        WAIT = 1'b1
    } MemState;

    // One operation coming from execute
    typedef struct packed {
        logic                   isValid;    // Operation present
        logic [`DATA_WIDTH-1:0] dataR;      // Result holding the address in its low bits
        logic [`DATA_WIDTH-1:0] dataB;      // Store data
        logic                   wrEnable;   // Store
        logic                   rdEnable;   // Load
        DataAccess              access;     // Size
        logic                   isUnsigned; // Zero-extend loads
        WrDataSel               wrDataSel;  // Write-back source
    } MemOp;

    // Data bus request with lanes already placed
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`ADDR_WIDTH-3:0] addr;       // Word address
        logic [`DATA_WIDTH-1:0] wrData;
        logic [3:0]             byteEn;
    } BusReq;

    typedef struct packed {
        logic                   ack;        // One-cycle pulse
        logic [`DATA_WIDTH-1:0] rdData;
    } BusRsp;

    // Pulses to the performance counters
    typedef struct packed {
        logic memRead;
        logic memWrite;
        logic alignError;
    } MemEvents;

endpackage

// File: logic/DataMemoryAdapter.sv
`timescale 1ns/10ps
`include "memStage_defs.svh"

module DataMemoryAdapter (
    input  logic                   i_clock,       // Clock
    input  logic                   i_rstN,        // Async reset, active low
    input  logic [`ADDR_WIDTH-1:0] i_addr,        // Byte address
    input  logic                   i_wrEnable,    // Store request
    input  logic                   i_rdEnable,    // Load request
    input  memStagePkg::DataAccess i_access,      // Access size
    input  logic                   i_isUnsigned,  // Zero-extend loads
    input  logic [`DATA_WIDTH-1:0] i_wrData,      // Store data in the low bits
    input  memStagePkg::BusRsp     i_rsp,         // Memory response
    output memStagePkg::BusReq     o_req,         // Memory request
    output logic [`DATA_WIDTH-1:0] o_rdData,      // Extended load data
    output logic                   o_busy,        // Access still in flight
    output logic                   o_alignError); // Misaligned access

    logic [1:0]             laneSel;    // Byte offset in the word
    logic                   accessReq;  // Any memory access wanted
    logic                   misaligned;
    logic [3:0]             byteEn;
    logic [`DATA_WIDTH-1:0] laneData;   // Store data on its lanes
    logic [`DATA_WIDTH-1:0] rdShifted;  // Addressed lane moved to bit 0
    logic                   pending;    // Request seen and not yet acked

    assign laneSel   = i_addr[1:0];
    assign accessReq = i_wrEnable | i_rdEnable;

    // --------------------------------------------------
    // Lane enables and store data placement
    // --------------------------------------------------
    always_comb begin
        case (i_access)
            memStagePkg::BYTE: begin
                misaligned = 1'b0;                      // Bytes fit anywhere
                byteEn     = 4'b0001 << laneSel;
                laneData   = {4{i_wrData[7:0]}};        // Copy on every lane
            end
            memStagePkg::HALF: begin
                misaligned = laneSel[0];                // Needs even address
                byteEn     = 4'b0011 << laneSel;
                laneData   = {2{i_wrData[15:0]}};
            end
            default: begin
                misaligned = |laneSel;                  // Word on multiple of 4
                byteEn     = 4'b1111;
                laneData   = i_wrData;
            end
        endcase
    end

    // Request goes out in the same cycle and never for a misaligned access
    always_comb begin
        o_req.valid  = accessReq & ~misaligned;
        o_req.write  = i_wrEnable;
        o_req.addr   = i_addr[`ADDR_WIDTH-1:2];         // Drop byte offset
        o_req.wrData = laneData;
        o_req.byteEn = byteEn;
    end

    assign o_alignError = accessReq & misaligned;
    assign o_busy       = o_req.valid & ~i_rsp.ack;    // Stall until ack

    // --------------------------------------------------
    // Load extraction and extension
    // --------------------------------------------------
    assign rdShifted = i_rsp.rdData >> {laneSel, 3'b000};

    always_comb begin
        case (i_access)
            memStagePkg::BYTE:
                o_rdData = {{(`DATA_WIDTH-8){~i_isUnsigned & rdShifted[7]}}, rdShifted[7:0]};
            memStagePkg::HALF:
                o_rdData = {{(`DATA_WIDTH-16){~i_isUnsigned & rdShifted[15]}},
                            rdShifted[15:0]};
            default:
                o_rdData = i_rsp.rdData;                // Full word without extension
        endcase
    end

    // Outstanding request marker
    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN)
            pending <= 1'b0;
        else
            pending <= o_req.valid & ~i_rsp.ack;        // Cleared by ack
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    noDualAccess: assert property (@(posedge i_clock) disable iff (!i_rstN)
        !(i_wrEnable && i_rdEnable))
        else $error("Load and store requested together");

    // Execute side must hold the operation while the bus waits
    reqStable: assert property (@(posedge i_clock) disable iff (!i_rstN)
        pending |-> (o_req == $past(o_req)))
        else $error("Bus request changed before ack");

endmodule

// File: logic/DataMemory.sv
`timescale 1ns/10ps
`include "memStage_defs.svh"

module DataMemory (
    input  logic               i_clock,  // Clock
    input  logic               i_rstN,   // Async reset, active low
    input  memStagePkg::BusReq i_req,    // Request from the adapter
    output memStagePkg::BusRsp o_rsp);   // Ack and read data

    localparam int latency  = `MEM_LATENCY;
    localparam int cntWidth = (latency > 1) ? $clog2(latency) : 1;

    logic [3:0][7:0]       ram [`MEM_WORDS];  // Byte lanes per word
    memStagePkg::MemState  state;
    logic [cntWidth-1:0]   cnt;               // Cycles spent on this request

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++)
            ram[i] = '0;
    end

    // Ack in the latency-th cycle and combinational when latency is 1
    assign o_rsp.ack    = i_req.valid && (cnt == cntWidth'(latency - 1));
    assign o_rsp.rdData = (o_rsp.ack && !i_req.write) ? ram[i_req.addr] : '0;

    // --------------------------------------------------
    // Latency sequencer
    // --------------------------------------------------
    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN) begin
            state <= memStagePkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                memStagePkg::IDLE:
                    if (i_req.valid && !o_rsp.ack) begin   // Multi-cycle access
                        state <= memStagePkg::WAIT;
                        cnt   <= cntWidth'(1);
                    end
                default:
                    if (o_rsp.ack) begin                   // Done and rearmed
                        state <= memStagePkg::IDLE;
                        cnt   <= '0;
                    end else
                        cnt <= cnt + 1'b1;
            endcase
        end
    end

    // Lane writes at the closing edge of the ack cycle
    always_ff @(posedge i_clock) begin
        if (o_rsp.ack && i_req.write)
            for (int lane = 0; lane < 4; lane++)
                if (i_req.byteEn[lane])
                    ram[i_req.addr][lane] <= i_req.wrData[8*lane +: 8];
    end

    // Each request sees a single ack cycle
    ackPulse: assert property (@(posedge i_clock) disable iff (!i_rstN)
        o_rsp.ack |=> (latency == 1 || !o_rsp.ack))
        else $error("Ack held for more than one cycle");

endmodule

// File: logic/PerfCounters.sv
`timescale 1ns/10ps
`include "memStage_defs.svh"

module PerfCounters (
    input  logic                    i_clock,     // Clock
    input  logic                    i_rstN,      // Async reset, active low
    input  memStagePkg::MemEvents   i_events,    // Completion pulses
    output logic [`COUNT_WIDTH-1:0] o_rdCount,   // Completed loads
    output logic [`COUNT_WIDTH-1:0] o_wrCount,   // Completed stores
    output logic [`COUNT_WIDTH-1:0] o_errCount); // Misaligned accesses

    logic [2:0]                    evVec;   // Error, write, read
    logic [2:0][`COUNT_WIDTH-1:0]  count;

    assign evVec = {i_events.alignError, i_events.memWrite, i_events.memRead};

    // --------------------------------------------------
    // Saturating counters
    // --------------------------------------------------
    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN)
            count <= '0;
        else
            for (int i = 0; i < 3; i++)
                if (evVec[i] && (count[i] != '1))     // Stop at max
                    count[i] <= count[i] + 1'b1;
    end

    assign o_rdCount  = count[0];
    assign o_wrCount  = count[1];
    assign o_errCount = count[2];

    // One operation completes per cycle
    singleEvent: assert property (@(posedge i_clock) disable iff (!i_rstN)
        $onehot0(evVec))
        else $error("More than one event in a cycle");

endmodule

// File: logic/StageMEM.sv
`timescale 1ns/10ps
`include "memStage_defs.svh"

module StageMEM (
    input  logic                   i_clock,       // Clock
    input  logic                   i_rstN,        // Async reset, active low
    input  memStagePkg::MemOp      i_op,          // Operation from execute
    input  memStagePkg::BusRsp     i_rsp,         // Data memory response
    output memStagePkg::BusReq     o_req,         // Data memory request
    output memStagePkg::MemEvents  o_events,      // Counter pulses
    output logic                   o_hazard,      // Stall upstream
    output logic                   o_alignError,  // Misaligned access
    output logic [`DATA_WIDTH-1:0] o_regWrData);  // Write-back value

    logic                   wrEnable;       // Valid store
    logic                   rdEnable;       // Valid load
    logic [`DATA_WIDTH-1:0] memRdData;
    logic                   memBusy;
    logic                   memAlignError;

    // Bubbles never touch memory
    assign wrEnable = i_op.wrEnable & i_op.isValid;
    assign rdEnable = i_op.rdEnable & i_op.isValid;

    // --------------------------------------------------
    // Memory adapter
    // --------------------------------------------------
    DataMemoryAdapter memAdapter (
        .i_clock      (i_clock),
        .i_rstN       (i_rstN),
        .i_addr       (i_op.dataR[`ADDR_WIDTH-1:0]),
        .i_wrEnable   (wrEnable),
        .i_rdEnable   (rdEnable),
        .i_access     (i_op.access),
        .i_isUnsigned (i_op.isUnsigned),
        .i_wrData     (i_op.dataB),
        .i_rsp        (i_rsp),
        .o_req        (o_req),
        .o_rdData     (memRdData),
        .o_busy       (memBusy),
        .o_alignError (memAlignError));

    assign o_hazard     = memBusy;            // Latency is the only stall
    assign o_alignError = memAlignError;

    // Pulses on the completing edge only
    always_comb begin
        o_events.memRead    = rdEnable & i_rsp.ack;
        o_events.memWrite   = wrEnable & i_rsp.ack;
        o_events.alignError = memAlignError;  // Completes at once
    end

    // Write-back selection
    assign o_regWrData = (i_op.wrDataSel == memStagePkg::SEL_MEMORY) ? memRdData
                                                                     : i_op.dataR;

endmodule

// File: logic/MemSubsystem.sv
`timescale 1ns/10ps
`include "memStage_defs.svh"

module MemSubsystem (
    input  logic                    i_clock,       // Clock
    input  logic                    i_rstN,        // Async reset, active low
    input  memStagePkg::MemOp       i_op,          // Operation from execute
    output logic                    o_hazard,      // Hold i_op while high
    output logic                    o_alignError,  // Misaligned access
    output logic [`DATA_WIDTH-1:0]  o_regWrData,   // Write-back value
    output logic [`COUNT_WIDTH-1:0] o_rdCount,     // Completed loads
    output logic [`COUNT_WIDTH-1:0] o_wrCount,     // Completed stores
    output logic [`COUNT_WIDTH-1:0] o_errCount);   // Alignment errors

    memStagePkg::BusReq    busReq;   // Stage to RAM
    memStagePkg::BusRsp    busRsp;   // RAM to stage
    memStagePkg::MemEvents events;   // Stage to counters

    // --------------------------------------------------
    // Memory stage
    // --------------------------------------------------
    StageMEM stageMem (
        .i_clock      (i_clock),
        .i_rstN       (i_rstN),
        .i_op         (i_op),
        .i_rsp        (busRsp),
        .o_req        (busReq),
        .o_events     (events),
        .o_hazard     (o_hazard),
        .o_alignError (o_alignError),
        .o_regWrData  (o_regWrData));

    // Data RAM behind the bus
    DataMemory dataMem (
        .i_clock (i_clock),
        .i_rstN  (i_rstN),
        .i_req   (busReq),
        .o_rsp   (busRsp));

    // --------------------------------------------------
    // Event counters
    // --------------------------------------------------
    PerfCounters perfCnt (
        .i_clock    (i_clock),
        .i_rstN     (i_rstN),
        .i_events   (events),
        .o_rdCount  (o_rdCount),
        .o_wrCount  (o_wrCount),
        .o_errCount (o_errCount));

endmodule

// File: verif/MemSubsystemTb.sv
`timescale 1ns/10ps
`include "memStage_defs.svh"

module MemSubsystemTb;

    localparam int maxOps     = 64;
    localparam int halfPeriod = 10;

    logic                    i_clock;
    logic                    i_rstN;
    memStagePkg::MemOp       i_op;
    logic                    o_hazard;
    logic                    o_alignError;
    logic [`DATA_WIDTH-1:0]  o_regWrData;
    logic [`COUNT_WIDTH-1:0] o_rdCount;
    logic [`COUNT_WIDTH-1:0] o_wrCount;
    logic [`COUNT_WIDTH-1:0] o_errCount;

    logic [31:0] testData [4*maxOps];        // Ctrl, dataR, dataB, expected per op
    logic [7:0]  shadow [2**`ADDR_WIDTH];    // Expected memory bytes
    int          numOps;
    int          cycleCount;
    int          cycleLimit;
    int          passCount;
    int          failCount;
    int          testErrors;                 // Mismatches in the current test
    int          expRd;
    int          expWr;
    int          expErr;

    MemSubsystem UUT (
        .i_clock      (i_clock),
        .i_rstN       (i_rstN),
        .i_op         (i_op),
        .o_hazard     (o_hazard),
        .o_alignError (o_alignError),
        .o_regWrData  (o_regWrData),
        .o_rdCount    (o_rdCount),
        .o_wrCount    (o_wrCount),
        .o_errCount   (o_errCount));

    always #halfPeriod i_clock = ~i_clock;  // 20 ns period

    // Run limit
    always @(posedge i_clock) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            testErrors++;
        end
    endtask

    // --------------------------------------------------
    // Reference model on the shadow memory
    // --------------------------------------------------
    task automatic modelOp(input logic [31:0] ctrl, input logic [31:0] dataR,
                           input logic [31:0] dataB, output logic [31:0] wbData,
                           output logic misaligned, output logic memAccess);
        logic [`ADDR_WIDTH-1:0] addr;
        int                     size;
        logic [31:0]            loaded;
        addr       = dataR[`ADDR_WIDTH-1:0];
        size       = (ctrl[13:12] == 2'd0) ? 1 : (ctrl[13:12] == 2'd1) ? 2 : 4;
        misaligned = ctrl[24] && (ctrl[20] || ctrl[16]) && (addr % size != 0);
        memAccess  = ctrl[24] && (ctrl[20] || ctrl[16]) && !misaligned;
        loaded     = '0;
        for (int i = 0; i < size; i++) begin
            if (memAccess && ctrl[20])
                shadow[addr + i] = dataB[8*i +: 8];     // Little endian lanes
            loaded[8*i +: 8] = shadow[addr + i];
        end
        if (size < 4 && !ctrl[8] && loaded[8*size-1])
            loaded = loaded | ~((32'd1 << (8*size)) - 1); // Sign extension
        wbData = ctrl[4] ? loaded : dataR;
    endtask

    initial begin
        logic [31:0] ctrl;
        logic [31:0] modelWb;
        logic        modelErr;
        logic        memAccess;
        int          stalls;
        int          gap;
        i_clock    = 1'b0;
        i_rstN     = 1'b0;
        i_op       = '0;
        cycleCount = 0;
        cycleLimit = 0;
        passCount  = 0;
        failCount  = 0;
        expRd      = 0;
        expWr      = 0;
        expErr     = 0;
        void'($urandom(53));
        for (int i = 0; i < 4*maxOps; i++)
            testData[i] = '1;                   // End marker where the file stops
        for (int i = 0; i < 2**`ADDR_WIDTH; i++)
            shadow[i] = '0;                     // RAM starts cleared
        $readmemh("verif/memStage_testdata.txt", testData);
        numOps = 0;
        while (numOps < maxOps && testData[4*numOps] !== '1)
            numOps++;
        cycleLimit = numOps * (`MEM_LATENCY + 4) + 100;

        repeat (10) @(posedge i_clock);
        @(negedge i_clock);
        i_rstN = 1'b1;

        for (int n = 0; n < numOps; n++) begin
            ctrl = testData[4*n];
            gap  = $urandom % 4;
            repeat (gap) begin
                @(negedge i_clock);
                i_op = '0;                      // Bubble
            end
            @(negedge i_clock);
            i_op.isValid    = ctrl[24];
            i_op.wrEnable   = ctrl[20];
            i_op.rdEnable   = ctrl[16];
            i_op.access     = memStagePkg::DataAccess'(ctrl[13:12]);
            i_op.isUnsigned = ctrl[8];
            i_op.wrDataSel  = memStagePkg::WrDataSel'(ctrl[4]);
            i_op.dataR      = testData[4*n+1];
            i_op.dataB      = testData[4*n+2];
            modelOp(ctrl, testData[4*n+1], testData[4*n+2], modelWb, modelErr, memAccess);

            // Sample just before each rising edge and hold the op while stalled
            stalls = 0;
            #(halfPeriod - 1);
            while (o_hazard) begin
                stalls++;
                @(negedge i_clock);
                #(halfPeriod - 1);
            end
            testErrors = 0;
            checkValue("o_regWrData", testData[4*n+3], o_regWrData);
            checkValue("o_alignError", 32'(ctrl[0]), 32'(o_alignError));
            checkValue("hazard cycles", memAccess ? `MEM_LATENCY - 1 : 0, stalls);
            checkValue("model write-back", testData[4*n+3], modelWb);
            checkValue("model align flag", 32'(ctrl[0]), 32'(modelErr));
            expRd  += (memAccess && ctrl[16]) ? 1 : 0;
            expWr  += (memAccess && ctrl[20]) ? 1 : 0;
            expErr += modelErr ? 1 : 0;
            @(posedge i_clock);                 // Completing edge
            if (testErrors == 0) begin
                passCount++;
                $display("Test %0d ok: ctrl %h addr %h, %0d stall cycles", n, ctrl[27:0],
                         testData[4*n+1], stalls);
            end else begin
                failCount++;
                $display("Test %0d failed with %0d mismatches", n, testErrors);
            end
        end

        // --------------------------------------------------
        // Counter totals
        // --------------------------------------------------
        @(negedge i_clock);
        i_op = '0;
        #(halfPeriod - 1);
        testErrors = 0;
        checkValue("o_rdCount", expRd, o_rdCount);
        checkValue("o_wrCount", expWr, o_wrCount);
        checkValue("o_errCount", expErr, o_errCount);
        if (testErrors == 0) begin
            passCount++;
            $display("Counters ok: %0d reads, %0d writes, %0d errors", expRd, expWr, expErr);
        end else begin
            failCount++;
            $display("Counters failed with %0d mismatches", testErrors);
        end

        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: verif/memStage_testdata.txt
// ctrl digits V W R A U S E: valid, store, load, size 0/1/2, unsigned, wb from memory, align error
// then dataR (low bits are the address), dataB (store data), expected write-back value
1102000 00000100 DEADBEEF 00000100  // Word store
1012010 00000100 00000000 DEADBEEF  // Word load back
1100000 00000200 000000A5 00000200  // Byte lane 0
1100000 00000201 0000003C 00000201  // Byte lane 1
1101000 00000202 00008E71 00000202  // Half lanes 2 and 3
1010010 00000200 00000000 FFFFFFA5
1010110 00000200 00000000 000000A5
1010010 00000201 00000000 0000003C
1011010 00000202 00000000 FFFF8E71
1011110 00000202 00000000 00008E71
1012010 00000200 00000000 8E713CA5  // Whole word, neighbours intact
1100000 00000303 00000080 00000303  // Byte lane 3
1010010 00000303 00000000 FFFFFF80
1012010 00000300 00000000 80000000
1000000 12345678 00000000 12345678  // Pass-through
0012000 00000100 00000000 00000100  // Bubble with load enable
0102000 00000100 11111111 00000100  // Bubble with store enable
1102001 00000101 CAFEF00D 00000101  // Misaligned word store
1011001 00000203 00000000 00000203  // Misaligned half load
1012001 00000302 00000000 00000302  // Misaligned word load
1012010 00000100 00000000 DEADBEEF  // Still unchanged
1101000 00000100 00001234 00000100
1012010 00000100 00000000 DEAD1234
1011010 00000102 00000000 FFFFDEAD

// File: verilog.f
+incdir+logic
logic/memStagePkg.sv
logic/DataMemoryAdapter.sv
logic/DataMemory.sv
logic/PerfCounters.sv
logic/StageMEM.sv
logic/MemSubsystem.sv
verif/MemSubsystemTb.sv

// File: run.sh
#!/bin/sh
# Build the memory stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module MemSubsystemTb -o MemSubsystemSim \
    && ./obj_dir/MemSubsystemSim | tee /dev/stderr | grep "^TEST PASS$" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
